// ==== compile.f ====
+incdir+.
wb_bus_pkg.sv
wb_dev_pkg.sv
wb_decode.sv
wb_ram.sv
wb_regs.sv
wb_subsys.sv
tb_wb_subsys.sv

// ==== Bender.yml ====
package:
  name: wb_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - wb_bus_pkg.sv
      - wb_dev_pkg.sv
      - wb_decode.sv
      - wb_ram.sv
      - wb_regs.sv
      - wb_subsys.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb_subsys.sv

// ==== wb_patterns.txt ====
# Columns: op adr wdata sel exp_data exp_err, all hex
# op 1 = write, 0 = read; exp_err 1 = err, 0 = ack; exp_data checked on reads only
# ID, scratch and counter after reset
0 80000000 00000000 f 57420001 0
0 80000004 00000000 f 00000000 0
0 80000008 00000000 f 00000000 0
# Scratch writes with full and partial byte selects
1 80000004 a5a5a5a5 f 00000000 0
0 80000004 00000000 f a5a5a5a5 0
1 80000004 11223344 3 00000000 0
0 80000004 00000000 f a5a53344 0
1 80000004 deadbeef 8 00000000 0
0 80000004 00000000 f dea53344 0
# Illegal register accesses
1 80000000 ffffffff f 00000000 1
1 80000008 ffffffff f 00000000 1
1 8000000c 12345678 f 00000000 1
0 8000000c 00000000 f 00000000 1
# Counter holds the three scratch writes, ID and scratch unchanged
0 80000008 00000000 f 00000003 0
0 80000000 00000000 f 57420001 0
0 80000004 00000000 f dea53344 0
# Unmapped addresses
0 40000000 00000000 f 00000000 1
1 40000000 cafef00d f 00000000 1
0 00010000 00000000 f 00000000 1
0 80010000 00000000 f 00000000 1
# RAM full-word writes and readback
1 00000000 01234567 f 00000000 0
1 00000004 89abcdef f 00000000 0
1 000003fc 0f0f0f0f f 00000000 0
0 00000000 00000000 f 01234567 0
0 00000004 00000000 f 89abcdef 0
0 000003fc 00000000 f 0f0f0f0f 0
# RAM single-byte writes over the words above
1 00000000 ffffffff 1 00000000 0
1 00000004 00000000 4 00000000 0
1 000003fc aaaaaaaa 8 00000000 0
1 00000000 77777777 2 00000000 0
0 00000000 00000000 f 012377ff 0
0 00000004 00000000 f 8900cdef 0
0 000003fc 00000000 f aa0f0f0f 0

// ==== tb_wb_subsys.sv ====
// Wishbone subsystem testbench driving pattern file accesses and a random RAM test
`default_nettype none
`timescale 1ns/100ps

`include "wb_soc_params.svh"

module tb_wb_subsys;

   // Cycles the master waits for ack or err before giving up
   localparam int RSP_WAIT = 8;
   // Random RAM writes that are each read back once
   localparam int RAND_WRITES = 32;

   // One access from the pattern file
   typedef struct packed {
      logic                we;
      wb_bus_pkg::wb_adr_t adr;
      wb_bus_pkg::wb_dat_t wdat;
      wb_bus_pkg::wb_sel_t sel;
      wb_bus_pkg::wb_dat_t exp_dat;
      logic                exp_err;
      logic [15:0]         line_no;
   } pattern_t;

   logic                clk = 1'b0;
   logic                rst_n;
   wb_bus_pkg::wb_m2s_t m_req;
   wb_bus_pkg::wb_s2m_t m_rsp;

   pattern_t            pat_q [$];
   wb_bus_pkg::wb_dat_t ref_mem [`WB_RAM_WORDS];
   logic [7:0]          rand_idx [RAND_WRITES];
   logic [31:0]         lfsr_q = 32'h6685;
   int                  pass_cnt = 0;
   int                  fail_cnt = 0;
   int                  cycle_cnt = 0;
   // Zero until the pattern count is known
   int                  cycle_limit = 0;

   wb_subsys dut0 (
      .clk_i   (clk),
      .rst_n_i (rst_n),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   // Watchdog limit scales with the number of accesses
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   // Galois LFSR with one shift per bit
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // Collect n random bits from the LFSR LSB per step
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r      = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
      return r;
   endfunction

   // Load all accesses from the pattern file
   task automatic load_patterns();
      int               fd;
      int               n;
      int               line_no;
      logic [8*128-1:0] line;
      logic [31:0]      f_op;
      logic [31:0]      f_adr;
      logic [31:0]      f_wd;
      logic [31:0]      f_sel;
      logic [31:0]      f_ed;
      logic [31:0]      f_er;
      pattern_t         p;
      line_no = 0;
      fd = $fopen("wb_patterns.txt", "r");
      if (fd == 0) begin
         $display("Error: could not open wb_patterns.txt");
         fail_cnt++;
         return;
      end
      while (!$feof(fd)) begin
         line = '0;
         n = $fgets(line, fd);
         line_no++;
         // Comment and blank lines give no fields
         if (n > 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_adr, f_wd, f_sel, f_ed, f_er);
            if (n == 6) begin
               p.we      = f_op[0];
               p.adr     = f_adr;
               p.wdat    = f_wd;
               p.sel     = f_sel[3:0];
               p.exp_dat = f_ed;
               p.exp_err = f_er[0];
               p.line_no = line_no[15:0];
               pat_q.push_back(p);
            end else if (n > 0) begin
               $display("Error: malformed line %0d in wb_patterns.txt", line_no);
               fail_cnt++;
            end
         end
      end
      $fclose(fd);
   endtask

   // One classic cycle with inputs changed and the response read on the falling edge
   task automatic run_access(input logic we, input wb_bus_pkg::wb_adr_t adr,
                             input wb_bus_pkg::wb_dat_t wdat, input wb_bus_pkg::wb_sel_t sel,
                             input wb_bus_pkg::wb_dat_t exp_dat, input logic exp_err,
                             input string label);
      int                  waited;
      logic                got;
      logic                ok;
      wb_bus_pkg::wb_s2m_t rsp;
      waited = 0;
      got    = 1'b0;
      ok     = 1'b1;
      rsp    = '0;
      @(negedge clk);
      m_req.adr = adr;
      m_req.dat = wdat;
      m_req.sel = sel;
      m_req.we  = we;
      m_req.cyc = 1'b1;
      m_req.stb = 1'b1;
      // Hold the request until ack or err shows up
      while (!got && waited < RSP_WAIT) begin
         @(negedge clk);
         waited++;
         if (m_rsp.ack || m_rsp.err) begin
            got = 1'b1;
            rsp = m_rsp;
         end
      end
      m_req.cyc = 1'b0;
      m_req.stb = 1'b0;
      m_req.we  = 1'b0;
      if (!got) begin
         $display("Error: %s got neither ack nor err within %0d cycles", label, RSP_WAIT);
         ok = 1'b0;
      end else begin
         if (rsp.ack !== !exp_err) begin
            $display("Mismatch m_rsp_o.ack: got %h expected %h", rsp.ack, !exp_err);
            ok = 1'b0;
         end
         if (rsp.err !== exp_err) begin
            $display("Mismatch m_rsp_o.err: got %h expected %h", rsp.err, exp_err);
            ok = 1'b0;
         end
         // Retry is never part of a response
         if (rsp.rty !== 1'b0) begin
            $display("Mismatch m_rsp_o.rty: got %h expected %h", rsp.rty, 1'b0);
            ok = 1'b0;
         end
         // Read data only means something on reads
         if (!we && rsp.dat !== exp_dat) begin
            $display("Mismatch m_rsp_o.dat: got %h expected %h", rsp.dat, exp_dat);
            ok = 1'b0;
         end
      end
      if (ok) begin
         pass_cnt++;
      end else begin
         fail_cnt++;
      end
      $display("%s: %s adr %h %s", label, we ? "write" : "read ", adr, ok ? "ok" : "FAILED");
   endtask

   initial begin
      logic [31:0] idx;
      logic [31:0] dat;
      m_req = '0;
      rst_n = 1'b0;
      load_patterns();
      cycle_limit = 10 * pat_q.size() + 10 * 2 * RAND_WRITES + 3;
      // Reset for 3 cycles and release on a falling edge
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Register, decode and RAM byte-lane accesses from the file
      foreach (pat_q[i]) begin
         run_access(pat_q[i].we, pat_q[i].adr, pat_q[i].wdat, pat_q[i].sel,
                    pat_q[i].exp_dat, pat_q[i].exp_err,
                    $sformatf("pattern line %0d", pat_q[i].line_no));
      end

      // Random full-word RAM writes with a reference copy of the last value per word
      for (int i = 0; i < RAND_WRITES; i++) begin
         idx         = take_bits(8);
         dat         = take_bits(32);
         rand_idx[i] = idx[7:0];
         ref_mem[idx[7:0]] = dat;
         run_access(1'b1, {22'd0, idx[7:0], 2'b00}, dat, 4'hf, '0, 1'b0,
                    $sformatf("random write %0d", i));
      end
      for (int i = 0; i < RAND_WRITES; i++) begin
         run_access(1'b0, {22'd0, rand_idx[i], 2'b00}, '0, 4'hf, ref_mem[rand_idx[i]], 1'b0,
                    $sformatf("random read %0d", i));
      end

      $display("Accesses passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wb_subsys.sv ====
// Wishbone subsystem top: address decoder in front of a word RAM and a control register block
`default_nettype none
`timescale 1ns/100ps

`include "wb_soc_params.svh"

module wb_subsys (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wb_bus_pkg::wb_m2s_t m_req_i,
   output wb_bus_pkg::wb_s2m_t m_rsp_o
);

   // Per-slave request and response buses
   wb_bus_pkg::wb_m2s_t s_req [`WB_SLAVES];
   wb_bus_pkg::wb_s2m_t s_rsp [`WB_SLAVES];

   // Memory map decode and response steering
   wb_decode u_decode (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .m_req_i (m_req_i),
      .m_rsp_o (m_rsp_o),
      .s_req_o (s_req),
      .s_rsp_i (s_rsp)
   );

   // Slave 0, word RAM
   wb_ram u_ram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (s_req[0]),
      .rsp_o   (s_rsp[0])
   );

   // Slave 1, control registers
   wb_regs u_regs (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (s_req[1]),
      .rsp_o   (s_rsp[1])
   );

endmodule

`default_nettype wire

// ==== wb_regs.sv ====
// Wishbone control register slave: ID, byte-writable scratch and scratch write counter
`default_nettype none
`timescale 1ns/100ps

`include "wb_soc_params.svh"

module wb_regs (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wb_bus_pkg::wb_m2s_t req_i,
   output wb_bus_pkg::wb_s2m_t rsp_o
);

   // Register map
   localparam wb_dev_pkg::reg_idx_t IDX_ID      = 2'd0;
   localparam wb_dev_pkg::reg_idx_t IDX_SCRATCH = 2'd1;
   localparam wb_dev_pkg::reg_idx_t IDX_WR_CNT  = 2'd2;

   wb_dev_pkg::slv_state_t state_q;
   wb_dev_pkg::reg_idx_t   reg_idx;
   wb_bus_pkg::wb_dat_t    scratch_q;
   wb_bus_pkg::wb_dat_t    wr_cnt_q;
   wb_bus_pkg::wb_dat_t    rd_mux;
   wb_bus_pkg::wb_dat_t    rd_dat_q;
   logic                   start;
   logic                   illegal;
   logic                   err_q;

   assign reg_idx = req_i.adr[3:2];
   assign start   = req_i.cyc && req_i.stb && (state_q == wb_dev_pkg::SLV_IDLE);

   // Index 3 is unmapped, ID and counter are read only
   assign illegal = !(reg_idx inside {IDX_ID, IDX_SCRATCH, IDX_WR_CNT}) ||
                    (req_i.we && (reg_idx != IDX_SCRATCH));

   always_comb begin
      case (reg_idx)
         IDX_ID:      rd_mux = `WB_REGS_ID;
         IDX_SCRATCH: rd_mux = scratch_q;
         IDX_WR_CNT:  rd_mux = wr_cnt_q;
         default:     rd_mux = '0;
      endcase
   end

   // Control state, scratch and counter
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= wb_dev_pkg::SLV_IDLE;
         err_q     <= 1'b0;
         scratch_q <= '0;
         wr_cnt_q  <= '0;
      end else if (state_q == wb_dev_pkg::SLV_RESP) begin
         state_q <= wb_dev_pkg::SLV_IDLE;
      end else if (start) begin
         state_q <= wb_dev_pkg::SLV_RESP;
         err_q   <= illegal;
         // Legal writes only ever target the scratch register
         if (req_i.we && !illegal) begin
            for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
               if (req_i.sel[b]) begin
                  scratch_q[8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
            wr_cnt_q <= wr_cnt_q + 1'b1;
         end
      end
   end

   // Read data, zero on an error response
   always_ff @(posedge clk_i) begin
      if (start) begin
         rd_dat_q <= illegal ? '0 : rd_mux;
      end
   end

   assign rsp_o.dat = rd_dat_q;
   assign rsp_o.ack = (state_q == wb_dev_pkg::SLV_RESP) && !err_q;
   assign rsp_o.err = (state_q == wb_dev_pkg::SLV_RESP) && err_q;
   assign rsp_o.rty = 1'b0;

   // err only follows a sampled request, never from idle
   a_err_resp: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rsp_o.err |-> (state_q == wb_dev_pkg::SLV_RESP) && $past(req_i.cyc && req_i.stb)
   );

endmodule

`default_nettype wire

// ==== wb_ram.sv ====
// Wishbone word RAM slave with byte-select writes and a registered one-cycle acknowledge
`default_nettype none
`timescale 1ns/100ps

`include "wb_soc_params.svh"

module wb_ram (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wb_bus_pkg::wb_m2s_t req_i,
   output wb_bus_pkg::wb_s2m_t rsp_o
);

   // Index width from the package type, word address starts at bit 2
   localparam int IDX_W = $bits(wb_dev_pkg::ram_idx_t);

   // Storage array
   wb_bus_pkg::wb_dat_t    mem [`WB_RAM_WORDS];

   wb_dev_pkg::slv_state_t state_q;
   wb_dev_pkg::ram_idx_t   word_idx;
   wb_bus_pkg::wb_dat_t    rd_dat_q;
   logic                   start;
   logic                   wr_en;

   assign word_idx = req_i.adr[IDX_W+1:2];

   // First sampled strobe of an access
   assign start = req_i.cyc && req_i.stb && (state_q == wb_dev_pkg::SLV_IDLE);
   assign wr_en = start && req_i.we;

   // Response sequencing
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= wb_dev_pkg::SLV_IDLE;
      end else begin
         case (state_q)
            wb_dev_pkg::SLV_IDLE: begin
               if (start) begin
                  state_q <= wb_dev_pkg::SLV_RESP;
               end
            end
            // Ack lasts one cycle, then back to idle
            default: begin
               state_q <= wb_dev_pkg::SLV_IDLE;
            end
         endcase
      end
   end

   // Byte-wise write, only selected lanes change
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
            if (req_i.sel[b]) begin
               mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
   end

   // Read data captured on the edge that starts the response
   // old contents on a write, which the master ignores
   always_ff @(posedge clk_i) begin
      if (start) begin
         rd_dat_q <= mem[word_idx];
      end
   end

   assign rsp_o.dat = rd_dat_q;
   assign rsp_o.ack = (state_q == wb_dev_pkg::SLV_RESP);
   // RAM accepts every address in its window
   assign rsp_o.err = 1'b0;
   assign rsp_o.rty = 1'b0;

   // Every access gets exactly one ack cycle
   a_ack_single: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rsp_o.ack |=> !rsp_o.ack
   );

endmodule

`default_nettype wire

// ==== wb_decode.sv ====
// Wishbone address decoder: selects a slave by memory map, fans out the request, muxes responses
`default_nettype none
`timescale 1ns/100ps

`include "wb_soc_params.svh"

module wb_decode (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wb_bus_pkg::wb_m2s_t m_req_i,
   output wb_bus_pkg::wb_s2m_t m_rsp_o,
   output wb_bus_pkg::wb_m2s_t s_req_o [`WB_SLAVES],
   input  wb_bus_pkg::wb_s2m_t s_rsp_i [`WB_SLAVES]
);

   // One bit per slave whose range matches the upper address bits
   logic [`WB_SLAVES-1:0] sel_vec;
   // Strobes as seen by the slaves
   logic [`WB_SLAVES-1:0] stb_vec;
   logic                  req_active;
   logic                  bus_err;

   assign req_active = m_req_i.cyc && m_req_i.stb;

   // Range compare per slave, masked by its enable
   assign sel_vec[0] = (`WB_S0_ENABLE != 0) &&
      (m_req_i.adr[`WB_ADDR_WIDTH-1 -: `WB_S0_RANGE_WIDTH] == `WB_S0_RANGE_MATCH);
   assign sel_vec[1] = (`WB_S1_ENABLE != 0) &&
      (m_req_i.adr[`WB_ADDR_WIDTH-1 -: `WB_S1_RANGE_WIDTH] == `WB_S1_RANGE_MATCH);

   // No match or several matches is a decode error
   // One-hot test: nonzero with a single bit set
   assign bus_err = (sel_vec == '0) || ((sel_vec & (sel_vec - 1'b1)) != '0);

   // Request fan-out
   for (genvar i = 0; i < `WB_SLAVES; i++) begin : g_fanout
      always_comb begin
         // Address, data, select, we and burst tags go to all slaves
         s_req_o[i]     = m_req_i;
         // Only the selected slave sees the cycle
         s_req_o[i].cyc = m_req_i.cyc && sel_vec[i];
         s_req_o[i].stb = m_req_i.stb && sel_vec[i];
      end

      assign stb_vec[i] = s_req_o[i].stb;
   end

   // Response mux from the selected slave
   always_comb begin
      m_rsp_o = '0;
      for (int i = 0; i < `WB_SLAVES; i++) begin
         if (sel_vec[i]) begin
            m_rsp_o = s_rsp_i[i];
         end
      end
      // Decode error overrides any slave response
      if (bus_err) begin
         m_rsp_o.dat = '0;
         m_rsp_o.ack = 1'b0;
         m_rsp_o.rty = 1'b0;
         // Answer in the same cycle as the strobe
         m_rsp_o.err = req_active;
      end
   end

   // At most one slave is strobed at any time
   a_single_stb: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (stb_vec & (stb_vec - 1'b1)) == '0
   );

   // The master never sees ack and err in one cycle
   a_ack_err_excl: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(m_rsp_o.ack && m_rsp_o.err)
   );

endmodule

`default_nettype wire

// ==== wb_dev_pkg.sv ====
// Device-side types shared by the Wishbone slaves: word indices and response sequencing states
`default_nettype none

`include "wb_soc_params.svh"

package wb_dev_pkg;

   // RAM word index, sized from the RAM depth
   typedef logic [$clog2(`WB_RAM_WORDS)-1:0] ram_idx_t;

   // Register index from address bits 3:2
   typedef logic [1:0] reg_idx_t;

   // Acknowledge sequencing shared by both slaves
   typedef enum logic {
      SLV_IDLE = 1'b0,
      // One-cycle response phase
      SLV_RESP = 1'b1
   } slv_state_t;

endpackage

`default_nettype wire

// ==== wb_bus_pkg.sv ====
// Wishbone B3 bus types: address, data and select vectors plus request and response structs
`default_nettype none

`include "wb_soc_params.svh"

package wb_bus_pkg;

   // Basic bus vectors
   typedef logic [`WB_ADDR_WIDTH-1:0] wb_adr_t;
   typedef logic [`WB_DATA_WIDTH-1:0] wb_dat_t;
   typedef logic [`WB_SEL_WIDTH-1:0]  wb_sel_t;

   // Master to slave request, classic cycle plus burst tags
   typedef struct packed {
      wb_adr_t    adr;
      wb_dat_t    dat;
      wb_sel_t    sel;
      logic       we;
      logic       cyc;
      logic       stb;
      // Burst tags, carried but unused by the slaves
      logic [2:0] cti;
      logic [1:0] bte;
   } wb_m2s_t;

   // Slave to master response
   typedef struct packed {
      wb_dat_t dat;
      logic    ack;
      logic    err;
      // Retry is never raised in this system
      logic    rty;
   } wb_s2m_t;

endpackage

`default_nettype wire

// ==== wb_soc_params.svh ====
// Wishbone subsystem parameters: bus widths, memory map, RAM depth and ID value
`ifndef WB_SOC_PARAMS_SVH
`define WB_SOC_PARAMS_SVH

// Bus widths in bits
`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32
`define WB_SEL_WIDTH (`WB_DATA_WIDTH / 8)

// Number of decoded slaves
`define WB_SLAVES 2

// Slave 0, word RAM at 0x0000_0000 .. 0x0000_ffff
`define WB_S0_ENABLE 1
`define WB_S0_RANGE_WIDTH 16
`define WB_S0_RANGE_MATCH 16'h0000

// Slave 1, control registers at 0x8000_0000 .. 0x8000_ffff
`define WB_S1_ENABLE 1
`define WB_S1_RANGE_WIDTH 16
`define WB_S1_RANGE_MATCH 16'h8000

// Device configuration
`define WB_RAM_WORDS 256
`define WB_REGS_ID 32'h5742_0001

`endif
